//--- fetch_top.f
fetch_pkg.sv
inst_ram.sv
mem_ctrl.sv
fetch_unit.sv
inst_queue.sv
fetch_top.sv
fetch_assertions.sv
tb_fetch_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the fetch front end testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_fetch_top -f fetch_top.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# keep running past the first assertion error so the testbench can report
output=$(./obj_dir/Vtb_fetch_top +verilator+error+limit+1000)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "All tests passed"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- tb_fetch_top.sv
module tb_fetch_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PROGRAM_WORDS = 2 ** fetch_pkg::LOAD_ADDR_W;
    localparam int READY_HIGH    = 0;
    localparam int READY_LOW     = 1;
    localparam int READY_RANDOM  = 2;

    logic                    clk;
    logic                    rst;
    logic                    rdy;
    fetch_pkg::load_t        load;
    fetch_pkg::redirect_t    redirect;
    logic                    deq_ready;
    logic                    deq_valid;
    fetch_pkg::fetch_entry_t deq_entry;

    int seed = 54;
    int ready_mode;
    int xfer_count = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int fail_mark = 0;
    bit timed_out = 1'b0;

    fetch_top dut (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .load     (load),
        .redirect (redirect),
        .deq_ready(deq_ready),
        .deq_valid(deq_valid),
        .deq_entry(deq_entry)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        if (deq_valid && deq_ready) begin
            xfer_count <= xfer_count + 1;
        end
    end

    // consumer side, random mode gives long low stretches
    initial begin : ready_driver
        int draw;
        int stretch_left;
        stretch_left = 0;
        deq_ready <= 1'b0;
        forever begin
            @(posedge clk);
            if (ready_mode == READY_RANDOM) begin
                if (stretch_left == 0) begin
                    draw = $random(seed);
                    deq_ready <= !deq_ready;
                    stretch_left = deq_ready ? 5 + (draw & 31) : 1 + (draw & 7);
                end else begin
                    stretch_left = stretch_left - 1;
                end
            end else begin
                deq_ready <= (ready_mode == READY_HIGH);
                stretch_left = 0;
            end
        end
    end

    task automatic wait_transfers(input int want, input int max_cycles);
        int start;
        int cycles;
        start = xfer_count;
        cycles = 0;
        while ((xfer_count - start) < want && cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        if ((xfer_count - start) < want) begin
            $display("timeout at %0t: only %0d of %0d transfers after %0d cycles",
                $time, xfer_count - start, want, cycles);
            timed_out = 1'b1;
        end
    endtask

    task automatic report_test(input string name);
        int new_fails;
        new_fails = dut.u_assert.fail_count - fail_mark;
        tests_run++;
        if (timed_out || new_fails != 0) begin
            tests_failed++;
            $display("test %0s: failed, %0d assertion failures", name, new_fails);
        end else begin
            $display("test %0s: passed", name);
        end
        timed_out = 1'b0;
        fail_mark = dut.u_assert.fail_count;
    endtask

    task automatic send_redirect();
        fetch_pkg::addr_t target;
        target = fetch_pkg::addr_t'($random(seed)) & 32'h0000_0ffc;
        @(posedge clk);
        redirect <= '{valid: 1'b1, target: target};
        @(posedge clk);
        redirect <= '0;
    endtask

    initial begin : main_flow
        int i;
        int k;
        logic [fetch_pkg::LOAD_ADDR_W-1:0] word_idx;
        fetch_pkg::inst_t                  word;
        rst <= 1'b1;
        rdy <= 1'b1;
        load <= '0;
        redirect <= '0;
        ready_mode <= READY_HIGH;

        // program goes in while the core is held in reset
        for (i = 0; i < PROGRAM_WORDS; i++) begin
            @(posedge clk);
            word_idx = i[fetch_pkg::LOAD_ADDR_W-1:0];
            word = $random(seed);
            load <= '{valid: 1'b1, addr: word_idx, data: word};
        end
        @(posedge clk);
        load <= '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        wait_transfers(16, 2000);
        report_test("reset_state");

        ready_mode <= READY_RANDOM;
        wait_transfers(300, 30000);
        report_test("sequence_and_data");

        ready_mode <= READY_LOW;
        for (k = 0; k < 40; k++) begin
            @(posedge clk);
        end
        ready_mode <= READY_HIGH;
        wait_transfers(40, 4000);
        report_test("back_pressure");

        // odd rounds redirect with a full queue
        for (k = 0; k < 6; k++) begin
            ready_mode <= (k % 2 == 1) ? READY_LOW : READY_RANDOM;
            repeat (20) @(posedge clk);
            send_redirect();
            ready_mode <= READY_RANDOM;
            wait_transfers(25, 5000);
        end
        report_test("redirect");

        for (k = 0; k < 5; k++) begin
            @(posedge clk);
            rdy <= 1'b0;
            repeat (25) @(posedge clk);
            rdy <= 1'b1;
            wait_transfers(30, 6000);
        end
        report_test("stall");

        $display("tests run %0d, passed %0d, failed %0d",
            tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- fetch_assertions.sv
module fetch_assertions (
    input logic                    clk,
    input logic                    rst,
    input logic                    rdy,
    input fetch_pkg::load_t        load,
    input fetch_pkg::redirect_t    redirect,
    input logic                    deq_ready,
    input logic                    deq_valid,
    input fetch_pkg::fetch_entry_t deq_entry,
    input logic                    push_valid,
    input fetch_pkg::mem_req_t     mem_req,
    input fetch_pkg::mem_resp_t    mem_resp,
    input logic                    credit_return
);
    timeunit 1ns;
    timeprecision 1ps;

    // shadow copy of every word written through the load port
    fetch_pkg::inst_t shadow [2 ** fetch_pkg::LOAD_ADDR_W];
    fetch_pkg::addr_t exp_pc;
    fetch_pkg::inst_t exp_inst;
    logic             xfer;
    int               fail_count = 0;

    assign xfer     = deq_valid && deq_ready;
    assign exp_inst = shadow[deq_entry.pc[fetch_pkg::LOAD_ADDR_W+1:2]];

    always_ff @(posedge clk) begin
        if (load.valid) begin
            shadow[load.addr] <= load.data;
        end
    end

    // next pc the decoder should see
    always_ff @(posedge clk) begin
        if (rst) begin
            exp_pc <= fetch_pkg::RESET_PC;
        end else if (redirect.valid) begin
            exp_pc <= redirect.target;
        end else if (xfer) begin
            exp_pc <= exp_pc + 32'd4;
        end
    end

    a_quiet_after_reset: assert property (@(posedge clk)
        rst |=> !deq_valid && !push_valid && !mem_req.valid && !mem_req.drop
            && !mem_resp.valid && !credit_return)
        else begin
            fail_count++;
            $error("control outputs active in the cycle after a reset cycle");
        end

    a_pc_order: assert property (@(posedge clk) disable iff (rst)
        xfer |-> deq_entry.pc == exp_pc)
        else begin
            fail_count++;
            $error("FAIL %0t deq_entry.pc got %h expected %h", $time,
                $sampled(deq_entry.pc), $sampled(exp_pc));
        end

    a_inst_data: assert property (@(posedge clk) disable iff (rst)
        xfer |-> deq_entry.inst == exp_inst)
        else begin
            fail_count++;
            $error("FAIL %0t deq_entry.inst got %h expected %h", $time,
                $sampled(deq_entry.inst), $sampled(exp_inst));
        end

    // old stream is gone right after a redirect
    a_flush_empties: assert property (@(posedge clk) disable iff (rst)
        redirect.valid |=> !deq_valid)
        else begin
            fail_count++;
            $error("queue still holds an entry in the cycle after a redirect");
        end

    a_hold_entry: assert property (@(posedge clk) disable iff (rst)
        deq_valid && !deq_ready && !redirect.valid |=> deq_valid && $stable(deq_entry))
        else begin
            fail_count++;
            $error("head entry changed or vanished while deq_ready was low");
        end

    a_stall_freezes: assert property (@(posedge clk) disable iff (rst)
        !rdy |=> !push_valid && !mem_req.valid)
        else begin
            fail_count++;
            $error("fetcher pushed or requested while rdy was low");
        end

endmodule

bind fetch_top fetch_assertions u_assert (
    .clk          (clk),
    .rst          (rst),
    .rdy          (rdy),
    .load         (load),
    .redirect     (redirect),
    .deq_ready    (deq_ready),
    .deq_valid    (deq_valid),
    .deq_entry    (deq_entry),
    .push_valid   (push_valid),
    .mem_req      (mem_req),
    .mem_resp     (mem_resp),
    .credit_return(credit_return)
);

//--- fetch_top.sv
module fetch_top #(
    parameter int ICACHE_LINES   = 64,
    parameter int QUEUE_DEPTH    = 8,
    parameter int MEM_LATENCY    = 3,
    parameter int RAM_WORDS_LOG2 = fetch_pkg::LOAD_ADDR_W
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    rdy,
    input  fetch_pkg::load_t        load,
    input  fetch_pkg::redirect_t    redirect,
    input  logic                    deq_ready,
    output logic                    deq_valid,
    output fetch_pkg::fetch_entry_t deq_entry
);

    fetch_pkg::mem_req_t       mem_req;
    fetch_pkg::mem_resp_t      mem_resp;
    logic [RAM_WORDS_LOG2-1:0] ram_addr;
    fetch_pkg::inst_t          ram_data;
    logic                      push_valid;
    fetch_pkg::fetch_entry_t   push_entry;
    logic                      credit_return;

    inst_ram #(
        .RAM_WORDS_LOG2(RAM_WORDS_LOG2)
    ) u_inst_ram (
        .clk    (clk),
        .load   (load),
        .rd_addr(ram_addr),
        .rd_data(ram_data)
    );

    mem_ctrl #(
        .MEM_LATENCY   (MEM_LATENCY),
        .RAM_WORDS_LOG2(RAM_WORDS_LOG2)
    ) u_mem_ctrl (
        .clk     (clk),
        .rst     (rst),
        .mem_req (mem_req),
        .mem_resp(mem_resp),
        .ram_addr(ram_addr),
        .ram_data(ram_data)
    );

    fetch_unit #(
        .ICACHE_LINES(ICACHE_LINES),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_fetch_unit (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .redirect     (redirect),
        .mem_req      (mem_req),
        .mem_resp     (mem_resp),
        .push_valid   (push_valid),
        .push_entry   (push_entry),
        .credit_return(credit_return)
    );

    // redirect valid doubles as the queue flush
    inst_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_inst_queue (
        .clk          (clk),
        .rst          (rst),
        .flush        (redirect.valid),
        .push_valid   (push_valid),
        .push_entry   (push_entry),
        .deq_valid    (deq_valid),
        .deq_entry    (deq_entry),
        .deq_ready    (deq_ready),
        .credit_return(credit_return)
    );

endmodule

//--- inst_queue.sv
module inst_queue #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  logic                    push_valid,
    input  fetch_pkg::fetch_entry_t push_entry,
    output logic                    deq_valid,
    output fetch_pkg::fetch_entry_t deq_entry,
    input  logic                    deq_ready,
    output logic                    credit_return
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    fetch_pkg::fetch_entry_t entries [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_deq;

    // no full check, the fetcher pushes only with a credit in hand
    assign do_push = push_valid && !flush;
    assign do_deq  = deq_valid && deq_ready;

    assign deq_valid     = (count != '0);
    assign deq_entry     = entries[rd_ptr];
    assign credit_return = do_deq;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_deq) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            count <= count + CNT_W'(do_push) - CNT_W'(do_deq);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wr_ptr] <= push_entry;
        end
    end

endmodule

//--- fetch_unit.sv
module fetch_unit #(
    parameter int ICACHE_LINES = 64,
    parameter int QUEUE_DEPTH  = 8
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    rdy,
    input  fetch_pkg::redirect_t    redirect,
    output fetch_pkg::mem_req_t     mem_req,
    input  fetch_pkg::mem_resp_t    mem_resp,
    output logic                    push_valid,
    output fetch_pkg::fetch_entry_t push_entry,
    input  logic                    credit_return
);

    localparam int IDX_W    = $clog2(ICACHE_LINES);
    localparam int TAG_W    = fetch_pkg::ADDR_W - IDX_W - 2;
    localparam int CREDIT_W = $clog2(QUEUE_DEPTH + 1);

    // how far the fill pc may run ahead before it would evict the current line
    localparam fetch_pkg::addr_t FILL_WINDOW = fetch_pkg::addr_t'(ICACHE_LINES * 4);

    typedef enum logic {
        FILL_IDLE,
        FILL_FETCH
    } fill_state_t;

    fill_state_t         fill_state;
    fetch_pkg::addr_t    pc;
    fetch_pkg::addr_t    fill_pc;
    logic [CREDIT_W-1:0] credits;

    // direct-mapped cache, one word per line
    logic [ICACHE_LINES-1:0] line_valid;
    logic [TAG_W-1:0]        tag_arr [ICACHE_LINES];
    fetch_pkg::inst_t        data_arr [ICACHE_LINES];

    logic             req_valid;
    logic             req_drop;
    fetch_pkg::addr_t req_addr;

    logic [IDX_W-1:0] pc_idx;
    logic [TAG_W-1:0] pc_tag;
    logic [IDX_W-1:0] fill_idx;
    logic [TAG_W-1:0] fill_tag;
    fetch_pkg::addr_t fill_ahead;
    logic             fill_behind;
    logic             fill_room;
    logic             fill_done;
    logic             hit;
    logic             do_push;

    assign pc_idx   = pc[IDX_W+1:2];
    assign pc_tag   = pc[fetch_pkg::ADDR_W-1:IDX_W+2];
    assign fill_idx = fill_pc[IDX_W+1:2];
    assign fill_tag = fill_pc[fetch_pkg::ADDR_W-1:IDX_W+2];

    assign hit     = line_valid[pc_idx] && (tag_arr[pc_idx] == pc_tag);
    assign do_push = rdy && hit && (credits != '0);

    // fill pc can fall behind when the pc hits stale but correct lines
    assign fill_ahead  = fill_pc - pc;
    assign fill_behind = fill_ahead[fetch_pkg::ADDR_W-1];
    assign fill_room   = fill_ahead < FILL_WINDOW;

    // a read already in flight still lands while rdy is low
    assign fill_done = (fill_state == FILL_FETCH) && mem_resp.valid;

    assign mem_req = '{valid: req_valid, drop: req_drop, addr: req_addr};

    always_ff @(posedge clk) begin
        if (rst) begin
            pc         <= fetch_pkg::RESET_PC;
            fill_pc    <= fetch_pkg::RESET_PC;
            fill_state <= FILL_IDLE;
            credits    <= CREDIT_W'(QUEUE_DEPTH);
            line_valid <= '0;
            push_valid <= 1'b0;
            req_valid  <= 1'b0;
            req_drop   <= 1'b0;
            req_addr   <= fetch_pkg::RESET_PC;
        end else if (redirect.valid) begin
            // queue is flushed in this same cycle
            pc         <= redirect.target;
            fill_pc    <= redirect.target;
            fill_state <= FILL_IDLE;
            credits    <= CREDIT_W'(QUEUE_DEPTH);
            push_valid <= 1'b0;
            req_valid  <= 1'b0;
            req_drop   <= 1'b1;
        end else begin
            push_valid <= do_push;
            req_valid  <= 1'b0;
            req_drop   <= 1'b0;
            credits    <= credits - CREDIT_W'(do_push) + CREDIT_W'(credit_return);

            if (do_push) begin
                pc <= pc + 32'd4;
            end

            case (fill_state)
                FILL_IDLE: begin
                    if (rdy) begin
                        if (fill_behind) begin
                            fill_pc <= pc;
                        end else if (fill_room) begin
                            req_valid  <= 1'b1;
                            req_addr   <= fill_pc;
                            fill_state <= FILL_FETCH;
                        end
                    end
                end
                FILL_FETCH: begin
                    if (fill_done) begin
                        line_valid[fill_idx] <= 1'b1;
                        fill_pc              <= fill_pc + 32'd4;
                        fill_state           <= FILL_IDLE;
                    end
                end
                default: fill_state <= FILL_IDLE;
            endcase
        end
    end

    // line contents
    always_ff @(posedge clk) begin
        if (fill_done && !redirect.valid) begin
            tag_arr[fill_idx]  <= fill_tag;
            data_arr[fill_idx] <= mem_resp.inst;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push && !redirect.valid) begin
            push_entry <= '{pc: pc, inst: data_arr[pc_idx]};
        end
    end

endmodule

//--- mem_ctrl.sv
module mem_ctrl #(
    // needs at least 2 so the registered RAM read lands in time
    parameter int MEM_LATENCY    = 3,
    parameter int RAM_WORDS_LOG2 = 10
) (
    input  logic                      clk,
    input  logic                      rst,
    input  fetch_pkg::mem_req_t       mem_req,
    output fetch_pkg::mem_resp_t      mem_resp,
    output logic [RAM_WORDS_LOG2-1:0] ram_addr,
    input  fetch_pkg::inst_t          ram_data
);

    localparam int CNT_W = (MEM_LATENCY > 2) ? $clog2(MEM_LATENCY) : 1;

    logic             pending;
    logic [CNT_W-1:0] cnt;
    fetch_pkg::addr_t addr_q;
    logic             resp_valid;
    fetch_pkg::inst_t resp_inst;
    logic             resp_fire;

    // byte address to word index
    assign ram_addr = addr_q[RAM_WORDS_LOG2+1:2];

    // last cycle of the countdown, unless the read is dropped now
    assign resp_fire = pending && (cnt == '0) && !mem_req.drop;

    assign mem_resp = '{valid: resp_valid, inst: resp_inst};

    always_ff @(posedge clk) begin
        if (rst) begin
            pending    <= 1'b0;
            cnt        <= '0;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            if (mem_req.drop) begin
                // pending read is forgotten, no response follows
                pending <= 1'b0;
            end else if (pending) begin
                if (cnt == '0) begin
                    pending    <= 1'b0;
                    resp_valid <= 1'b1;
                end else begin
                    cnt <= cnt - 1'b1;
                end
            end else if (mem_req.valid) begin
                pending <= 1'b1;
                cnt     <= CNT_W'(MEM_LATENCY - 1);
            end
        end
    end

    // request address held for the whole read
    always_ff @(posedge clk) begin
        if (!pending && mem_req.valid) begin
            addr_q <= mem_req.addr;
        end
    end

    always_ff @(posedge clk) begin
        if (resp_fire) begin
            resp_inst <= ram_data;
        end
    end

endmodule

//--- inst_ram.sv
module inst_ram #(
    parameter int RAM_WORDS_LOG2 = 10
) (
    input  logic                      clk,
    input  fetch_pkg::load_t          load,
    input  logic [RAM_WORDS_LOG2-1:0] rd_addr,
    output fetch_pkg::inst_t          rd_data
);

    localparam int RAM_WORDS = 2 ** RAM_WORDS_LOG2;

    fetch_pkg::inst_t mem [RAM_WORDS];

    // program load port
    always_ff @(posedge clk) begin
        if (load.valid) begin
            mem[load.addr] <= load.data;
        end
    end

    // registered read, data one cycle after the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- fetch_pkg.sv
package fetch_pkg;

    localparam int ADDR_W = 32;
    localparam int INST_W = 32;

    // word index width of the load port
    // the top level RAM_WORDS_LOG2 defaults to this value
    localparam int LOAD_ADDR_W = 10;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [INST_W-1:0] inst_t;

    localparam addr_t RESET_PC = '0;

    // fetched instruction on its way to the decoder
    typedef struct packed {
        addr_t pc;
        inst_t inst;
    } fetch_entry_t;

    // fetcher to memory controller
    typedef struct packed {
        logic  valid;
        logic  drop;
        addr_t addr;
    } mem_req_t;

    // memory controller to fetcher
    typedef struct packed {
        logic  valid;
        inst_t inst;
    } mem_resp_t;

    // committed jump from the reorder buffer
    typedef struct packed {
        logic  valid;
        addr_t target;
    } redirect_t;

    // program load into the instruction RAM
    typedef struct packed {
        logic                   valid;
        logic [LOAD_ADDR_W-1:0] addr;
        inst_t                  data;
    } load_t;

endpackage
